// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_conv_engine
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/cmac_lane.sv
`timescale 1ns/10ps
`default_nettype none

// complex multiply-accumulate for one lane
module cmac_lane (
  input  wire                      clk,
  input  wire                      reset,
  input  wire conv_pkg::lane_op_t  lane_op,
  output conv_pkg::acc_t           lane_sum,
  output logic                     sum_valid
);

  conv_pkg::acc_t     acc;
  conv_pkg::acc_t     prod;
  conv_pkg::acc_t     base;
  logic signed [31:0] rr;
  logic signed [31:0] ii;
  logic signed [31:0] ri;
  logic signed [31:0] ir;

  // partial products, sign extended to 32 bits
  assign rr = lane_op.image.re * lane_op.kernel.re;
  assign ii = lane_op.image.im * lane_op.kernel.im;
  assign ri = lane_op.image.re * lane_op.kernel.im;
  assign ir = lane_op.image.im * lane_op.kernel.re;

  assign prod.re = rr - ii;
  assign prod.im = ri + ir;

  // first operand of a pass starts a fresh sum
  assign base = lane_op.first ? '0 : acc;

  always_ff @(posedge clk) begin
    if (lane_op.valid) begin
      acc.re <= base.re + prod.re;
      acc.im <= base.im + prod.im;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= lane_op.valid && lane_op.last;
    end
  end

  assign lane_sum = acc;

endmodule

`default_nettype wire

// File: hw/conv_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

// frequency-domain convolution engine
module conv_engine_top #(
  parameter int IMAGE_DEPTH_BITS  = 4,
  parameter int KERNEL_DEPTH_BITS = 6,
  parameter int FIFO_DEPTH_BITS   = 3
) (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       start,
  input  wire conv_pkg::cfg_t       cfg,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire conv_pkg::line_t      in_line,
  output logic                      out_valid,
  input  wire                       out_ready,
  output conv_pkg::result_t         out_word,
  output logic                      done
);

  logic [1:0]                              bank_full;
  logic                                    rd_bank;
  logic [IMAGE_DEPTH_BITS-1:0]             rd_image_addr;
  logic [KERNEL_DEPTH_BITS-1:0]            rd_kernel_addr;
  logic                                    bank_release;
  conv_pkg::line_t                         image_line;
  conv_pkg::line_t                         kernel_line;
  logic                                    pass_room;
  logic                                    pass_start;
  conv_pkg::lane_op_t [conv_pkg::LANES-1:0] lane_op;
  conv_pkg::acc_t [conv_pkg::LANES-1:0]     lane_sum;
  logic [conv_pkg::LANES-1:0]              sum_valid;

  tile_loader #(
    .IMAGE_DEPTH_BITS  (IMAGE_DEPTH_BITS),
    .KERNEL_DEPTH_BITS (KERNEL_DEPTH_BITS)
  ) u_loader (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .cfg            (cfg),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .in_line        (in_line),
    .rd_bank        (rd_bank),
    .rd_image_addr  (rd_image_addr),
    .rd_kernel_addr (rd_kernel_addr),
    .bank_release   (bank_release),
    .bank_full      (bank_full),
    .image_line     (image_line),
    .kernel_line    (kernel_line)
  );

  mac_sequencer #(
    .IMAGE_DEPTH_BITS  (IMAGE_DEPTH_BITS),
    .KERNEL_DEPTH_BITS (KERNEL_DEPTH_BITS)
  ) u_seq (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .cfg            (cfg),
    .bank_full      (bank_full),
    .pass_room      (pass_room),
    .pass_start     (pass_start),
    .rd_bank        (rd_bank),
    .rd_image_addr  (rd_image_addr),
    .rd_kernel_addr (rd_kernel_addr),
    .bank_release   (bank_release),
    .image_line     (image_line),
    .kernel_line    (kernel_line),
    .lane_op        (lane_op)
  );

  for (genvar j = 0; j < conv_pkg::LANES; j++) begin : g_lane
    cmac_lane u_lane (
      .clk       (clk),
      .reset     (reset),
      .lane_op   (lane_op[j]),
      .lane_sum  (lane_sum[j]),
      .sum_valid (sum_valid[j])
    );
  end

  result_drain #(
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) u_drain (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cfg        (cfg),
    .lane_sum   (lane_sum),
    .sum_valid  (sum_valid),
    .pass_start (pass_start),
    .pass_room  (pass_room),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_word   (out_word),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: hw/conv_pkg.sv
`default_nettype none

// shared types of the frequency-domain convolution engine
package conv_pkg;

  // complex samples per beat, and compute lanes
  localparam int LANES = 4;

  typedef struct packed {
    logic signed [15:0] re;
    logic signed [15:0] im;
  } sample_t;

  // one input beat, lane j in element j
  typedef sample_t [LANES-1:0] line_t;

  // accumulator, both parts wrap modulo 2^32
  typedef struct packed {
    logic signed [31:0] re;
    logic signed [31:0] im;
  } acc_t;

  typedef acc_t [LANES-1:0] result_t;

  typedef struct packed {
    logic [7:0]  num_maps;     // D1
    logic [7:0]  num_kernels;  // D2
    logic [15:0] num_tiles;
  } cfg_t;

  typedef struct packed {
    logic    valid;
    logic    first;
    logic    last;
    sample_t image;
    sample_t kernel;
  } lane_op_t;

  typedef enum logic [1:0] {
    BANK_VACANT,
    BANK_FILL,
    BANK_FULL,
    BANK_DRAIN
  } bank_state_t;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_KERNEL,
    LOAD_IMAGE,
    LOAD_DONE
  } load_state_t;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_PASS,
    EXEC_RELEASE
  } exec_state_t;

endpackage

`default_nettype wire

// File: hw/mac_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

// walks every kernel against the tile in the current bank
module mac_sequencer #(
  parameter int IMAGE_DEPTH_BITS  = 4,
  parameter int KERNEL_DEPTH_BITS = 6
) (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire                                    start,
  input  wire conv_pkg::cfg_t                    cfg,
  input  wire [1:0]                              bank_full,
  input  wire                                    pass_room,
  output logic                                   pass_start,
  output logic                                   rd_bank,
  output logic [IMAGE_DEPTH_BITS-1:0]            rd_image_addr,
  output logic [KERNEL_DEPTH_BITS-1:0]           rd_kernel_addr,
  output logic                                   bank_release,
  input  wire conv_pkg::line_t                   image_line,
  input  wire conv_pkg::line_t                   kernel_line,
  output conv_pkg::lane_op_t [conv_pkg::LANES-1:0] lane_op
);

  conv_pkg::exec_state_t state;
  conv_pkg::cfg_t        cfg_r;

  logic                         bank;
  logic [7:0]                   map_cnt;
  logic [7:0]                   krn_cnt;
  logic [KERNEL_DEPTH_BITS-1:0] krn_base;
  logic                         issue;
  logic                         map_last;
  logic                         krn_last;
  logic                         op_valid;
  logic                         op_first;
  logic                         op_last;

  assign issue    = state == conv_pkg::EXEC_PASS;
  assign map_last = map_cnt == cfg_r.num_maps - 8'd1;
  assign krn_last = krn_cnt == cfg_r.num_kernels - 8'd1;

  // kernel k of the tile lives at k*D1 in the kernel store
  assign rd_bank        = bank;
  assign rd_image_addr  = map_cnt[IMAGE_DEPTH_BITS-1:0];
  assign rd_kernel_addr = krn_base + map_cnt[KERNEL_DEPTH_BITS-1:0];
  assign bank_release   = state == conv_pkg::EXEC_RELEASE;

  // each pass reserves one result FIFO entry as it begins
  assign pass_start = (state == conv_pkg::EXEC_IDLE && bank_full[bank] && pass_room) ||
                      (issue && map_last && !krn_last && pass_room);

  always_ff @(posedge clk) begin
    if (start) begin
      cfg_r <= cfg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= conv_pkg::EXEC_IDLE;
      bank     <= 1'b0;
      map_cnt  <= '0;
      krn_cnt  <= '0;
      krn_base <= '0;
      op_valid <= 1'b0;
      op_first <= 1'b0;
      op_last  <= 1'b0;
    end else begin
      // flags follow the address by one cycle, like the read data
      op_valid <= issue;
      op_first <= issue && map_cnt == 8'd0;
      op_last  <= issue && map_last;
      if (start) begin
        state    <= conv_pkg::EXEC_IDLE;
        bank     <= 1'b0;
        map_cnt  <= '0;
        krn_cnt  <= '0;
        krn_base <= '0;
      end else begin
        case (state)
          conv_pkg::EXEC_IDLE: begin
            if (bank_full[bank] && pass_room) begin
              state <= conv_pkg::EXEC_PASS;
            end
          end
          conv_pkg::EXEC_PASS: begin
            if (map_last) begin
              map_cnt <= '0;
              if (krn_last) begin
                state <= conv_pkg::EXEC_RELEASE;
              end else begin
                krn_cnt  <= krn_cnt + 8'd1;
                krn_base <= krn_base + cfg_r.num_maps[KERNEL_DEPTH_BITS-1:0];
                // no room for the next sum, park until the FIFO drains
                if (!pass_room) begin
                  state <= conv_pkg::EXEC_IDLE;
                end
              end
            end else begin
              map_cnt <= map_cnt + 8'd1;
            end
          end
          conv_pkg::EXEC_RELEASE: begin
            bank     <= ~bank;
            krn_cnt  <= '0;
            krn_base <= '0;
            state    <= conv_pkg::EXEC_IDLE;
          end
          default: state <= conv_pkg::EXEC_IDLE;
        endcase
      end
    end
  end

  // split both lines into one operand per lane
  for (genvar j = 0; j < conv_pkg::LANES; j++) begin : g_op
    assign lane_op[j] = {op_valid, op_first, op_last, image_line[j], kernel_line[j]};
  end

endmodule

`default_nettype wire

// File: hw/result_drain.sv
`timescale 1ns/10ps
`default_nettype none

// result FIFO with pass reservations, output stream and job completion
module result_drain #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire                                  start,
  input  wire conv_pkg::cfg_t                  cfg,
  input  wire conv_pkg::acc_t [conv_pkg::LANES-1:0] lane_sum,
  input  wire [conv_pkg::LANES-1:0]            sum_valid,
  input  wire                                  pass_start,
  output logic                                 pass_room,
  output logic                                 out_valid,
  input  wire                                  out_ready,
  output conv_pkg::result_t                    out_word,
  output logic                                 done
);

  localparam int DEPTH = 2**FIFO_DEPTH_BITS;

  conv_pkg::result_t fifo_mem [DEPTH];

  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [FIFO_DEPTH_BITS:0]   count;
  logic [FIFO_DEPTH_BITS:0]   in_flight;
  logic [23:0]                out_cnt;
  logic [23:0]                total_r;
  logic                       push;
  logic                       pop;

  // lanes run in lockstep, so all sums arrive together
  assign push = &sum_valid;
  assign pop  = out_valid && out_ready;

  assign out_valid = count != '0;
  assign out_word  = fifo_mem[rd_ptr];
  assign pass_room = count + in_flight < (FIFO_DEPTH_BITS+1)'(DEPTH);

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= conv_pkg::result_t'(lane_sum);
    end
    if (start) begin
      total_r <= cfg.num_tiles * cfg.num_kernels;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_flight <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count + (FIFO_DEPTH_BITS+1)'(push) - (FIFO_DEPTH_BITS+1)'(pop);
      // a reservation turns into a queued word when its sum lands
      in_flight <= in_flight + (FIFO_DEPTH_BITS+1)'(pass_start) -
                   (FIFO_DEPTH_BITS+1)'(push);
    end
  end

  // done rises with the last word of the job and holds until the next start
  always_ff @(posedge clk) begin
    if (reset) begin
      out_cnt <= '0;
      done    <= 1'b0;
    end else if (start) begin
      out_cnt <= '0;
      done    <= 1'b0;
    end else if (pop) begin
      out_cnt <= out_cnt + 24'd1;
      if (out_cnt == total_r - 24'd1) begin
        done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/tile_loader.sv
`timescale 1ns/10ps
`default_nettype none

// input side: kernel store, two image banks and the bank status machines
module tile_loader #(
  parameter int IMAGE_DEPTH_BITS  = 4,
  parameter int KERNEL_DEPTH_BITS = 6
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          start,
  input  wire conv_pkg::cfg_t          cfg,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  wire conv_pkg::line_t         in_line,
  input  wire                          rd_bank,
  input  wire [IMAGE_DEPTH_BITS-1:0]   rd_image_addr,
  input  wire [KERNEL_DEPTH_BITS-1:0]  rd_kernel_addr,
  input  wire                          bank_release,
  output logic [1:0]                   bank_full,
  output conv_pkg::line_t              image_line,
  output conv_pkg::line_t              kernel_line
);

  conv_pkg::load_state_t state;
  conv_pkg::bank_state_t bank_st [2];
  conv_pkg::cfg_t        cfg_r;

  logic [15:0] krn_cnt;
  logic [15:0] krn_total;
  logic [7:0]  map_cnt;
  logic [15:0] tile_cnt;
  logic        wr_bank;
  logic        beat;
  logic        krn_we;
  logic        img_we;
  logic        map_last;

  conv_pkg::line_t krn_mem [2**KERNEL_DEPTH_BITS];
  // both banks in one array, bank select is the top address bit
  conv_pkg::line_t img_mem [2**(IMAGE_DEPTH_BITS+1)];

  assign krn_total = cfg_r.num_maps * cfg_r.num_kernels;
  assign map_last  = map_cnt == cfg_r.num_maps - 8'd1;

  // image beats stall while the write bank still holds an unread tile
  always_comb begin
    case (state)
      conv_pkg::LOAD_KERNEL: in_ready = 1'b1;
      conv_pkg::LOAD_IMAGE:  in_ready = bank_st[wr_bank] == conv_pkg::BANK_VACANT ||
                                        bank_st[wr_bank] == conv_pkg::BANK_FILL;
      default:               in_ready = 1'b0;
    endcase
  end

  assign beat   = in_valid && in_ready;
  assign krn_we = beat && state == conv_pkg::LOAD_KERNEL;
  assign img_we = beat && state == conv_pkg::LOAD_IMAGE;

  always_ff @(posedge clk) begin
    if (start) begin
      cfg_r <= cfg;
    end
  end

  // kernels first, then tiles of D1 beats alternating between banks
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= conv_pkg::LOAD_IDLE;
      krn_cnt  <= '0;
      map_cnt  <= '0;
      tile_cnt <= '0;
      wr_bank  <= 1'b0;
    end else if (start) begin
      state    <= conv_pkg::LOAD_KERNEL;
      krn_cnt  <= '0;
      map_cnt  <= '0;
      tile_cnt <= '0;
      wr_bank  <= 1'b0;
    end else begin
      case (state)
        conv_pkg::LOAD_KERNEL: begin
          if (krn_we) begin
            krn_cnt <= krn_cnt + 16'd1;
            if (krn_cnt == krn_total - 16'd1) begin
              state <= conv_pkg::LOAD_IMAGE;
            end
          end
        end
        conv_pkg::LOAD_IMAGE: begin
          if (img_we) begin
            if (map_last) begin
              map_cnt  <= '0;
              wr_bank  <= ~wr_bank;
              tile_cnt <= tile_cnt + 16'd1;
              // last tile of the job, stop accepting beats
              if (tile_cnt == cfg_r.num_tiles - 16'd1) begin
                state <= conv_pkg::LOAD_DONE;
              end
            end else begin
              map_cnt <= map_cnt + 8'd1;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  // one status machine per image bank
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (reset || start) begin
        bank_st[b] <= conv_pkg::BANK_VACANT;
      end else begin
        case (bank_st[b])
          conv_pkg::BANK_VACANT: begin
            // with D1 = 1 the first beat already completes the tile
            if (img_we && wr_bank == b[0]) begin
              bank_st[b] <= map_last ? conv_pkg::BANK_FULL : conv_pkg::BANK_FILL;
            end
          end
          conv_pkg::BANK_FILL: begin
            if (img_we && wr_bank == b[0] && map_last) begin
              bank_st[b] <= conv_pkg::BANK_FULL;
            end
          end
          conv_pkg::BANK_FULL: begin
            if (rd_bank == b[0]) begin
              bank_st[b] <= conv_pkg::BANK_DRAIN;
            end
          end
          conv_pkg::BANK_DRAIN: begin
            if (bank_release && rd_bank == b[0]) begin
              bank_st[b] <= conv_pkg::BANK_VACANT;
            end
          end
          default: bank_st[b] <= conv_pkg::BANK_VACANT;
        endcase
      end
    end
  end

  // a draining bank still counts as full for the sequencer
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bank_full[b] = bank_st[b] == conv_pkg::BANK_FULL ||
                     bank_st[b] == conv_pkg::BANK_DRAIN;
    end
  end

  always_ff @(posedge clk) begin
    if (krn_we) begin
      krn_mem[krn_cnt[KERNEL_DEPTH_BITS-1:0]] <= in_line;
    end
    if (img_we) begin
      img_mem[{wr_bank, map_cnt[IMAGE_DEPTH_BITS-1:0]}] <= in_line;
    end
    image_line  <= img_mem[{rd_bank, rd_image_addr}];
    kernel_line <= krn_mem[rd_kernel_addr];
  end

endmodule

`default_nettype wire

// File: sim/tb_conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_engine;

  localparam int BEAT_TIMEOUT  = 2000;
  localparam int WORD_TIMEOUT  = 5000;
  localparam int STALL_TIMEOUT = 3000;
  localparam int STALL_CYCLES  = 24;

  logic              clk;
  logic              reset;
  logic              start;
  conv_pkg::cfg_t    cfg;
  logic              in_valid;
  logic              in_ready;
  conv_pkg::line_t   in_line;
  logic              out_valid;
  logic              out_ready = 1'b0;
  conv_pkg::result_t out_word;
  logic              done;

  // job data kept for the reference model
  conv_pkg::line_t   krn_store [64];
  conv_pkg::line_t   img_store [64];
  conv_pkg::result_t exp_q [$];

  logic [31:0] data_rng;
  logic [31:0] ready_rng;
  int          ready_mode;  // 0 always ready, 1 random, 2 held low
  int          errors;
  int          words_seen;
  int          beats_sent;
  int          tests_run;

  conv_engine_top uut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .cfg       (cfg),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_line   (in_line),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // lane j of word k in tile t sums image times kernel over the maps, wrapping mod 2^32
  function automatic conv_pkg::result_t ref_word(input int d1, input int k, input int t);
    conv_pkg::result_t r;
    conv_pkg::sample_t x;
    conv_pkg::sample_t w;
    int re;
    int im;
    for (int j = 0; j < conv_pkg::LANES; j++) begin
      re = 0;
      im = 0;
      for (int m = 0; m < d1; m++) begin
        x = img_store[t * d1 + m][j];
        w = krn_store[k * d1 + m][j];
        // (a+bi)(c+di) = (ac-bd) + (ad+bc)i
        re = re + int'(x.re) * int'(w.re) - int'(x.im) * int'(w.im);
        im = im + int'(x.re) * int'(w.im) + int'(x.im) * int'(w.re);
      end
      r[j].re = re;
      r[j].im = im;
    end
    return r;
  endfunction

  // pick out_ready and compare whatever transfers at the next rising edge
  always @(negedge clk) begin : compare_out
    conv_pkg::result_t want;
    ready_rng = xorshift(ready_rng);
    case (ready_mode)
      0: out_ready = 1'b1;
      1: out_ready = ready_rng[3];
      default: out_ready = 1'b0;
    endcase
    if (out_valid && out_ready) begin
      words_seen++;
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: output word %h arrived with none expected", $time, out_word);
        errors++;
      end else begin
        want = exp_q.pop_front();
        if (out_word !== want) begin
          $display("MISMATCH at %0t: out_word expected %h got %h", $time, want, out_word);
          errors++;
        end
        if (done !== 1'b0) begin
          $display("ERROR at %0t: done was high before the last word of the job", $time);
          errors++;
        end
      end
    end
  end

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic fill_random(input int d1, input int d2, input int tiles);
    for (int i = 0; i < d1 * d2 + d1 * tiles; i++) begin
      for (int j = 0; j < conv_pkg::LANES; j++) begin
        data_rng = xorshift(data_rng);
        if (i < d1 * d2) begin
          krn_store[i][j] = data_rng;
        end else begin
          img_store[i - d1 * d2][j] = data_rng;
        end
      end
    end
  endtask

  // sends one beat after an optional gap and returns at the falling edge after the transfer
  task automatic send_beat(input conv_pkg::line_t l, input int gap);
    int waited;
    if (gap > 0) begin
      in_valid = 1'b0;
      repeat (gap) @(negedge clk);
    end
    in_valid = 1'b1;
    in_line  = l;
    waited   = 0;
    while (!in_ready) begin
      @(negedge clk);
      waited++;
      if (waited > BEAT_TIMEOUT) abort_run("input beat was never accepted");
    end
    @(negedge clk);
    beats_sent++;
  endtask

  // kernels first and then the image tiles in order
  task automatic feed_job(input int d1, input int d2, input int tiles, input bit gaps);
    int gap;
    int nk;
    nk = d1 * d2;
    beats_sent = 0;
    for (int i = 0; i < nk + d1 * tiles; i++) begin
      gap = 0;
      if (gaps) begin
        data_rng = xorshift(data_rng);
        gap = data_rng[0] ? int'(data_rng[3:1]) : 0;
      end
      send_beat((i < nk) ? krn_store[i] : img_store[i - nk], gap);
    end
    in_valid = 1'b0;
  endtask

  // in_ready has to fall before the input runs out while out_ready is held low
  task automatic watch_stall(input int total, input int rmode);
    int waited;
    int low;
    waited = 0;
    low    = 0;
    while (low < STALL_CYCLES) begin
      @(negedge clk);
      waited++;
      low = in_ready ? 0 : low + 1;
      if (waited > STALL_TIMEOUT) abort_run("in_ready never dropped under back-pressure");
    end
    if (beats_sent >= total) begin
      $display("ERROR at %0t: in_ready dropped only after the last input beat", $time);
      errors++;
    end
    ready_mode = rmode;
  endtask

  task automatic start_job(input int d1, input int d2, input int tiles);
    cfg.num_maps    = 8'(d1);
    cfg.num_kernels = 8'(d2);
    cfg.num_tiles   = 16'(tiles);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (done !== 1'b0) begin
      $display("MISMATCH at %0t: done expected 0 got %b", $time, done);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("MISMATCH at %0t: in_ready expected 1 got %b", $time, in_ready);
      errors++;
    end
  endtask

  task automatic run_job(input int num, input string name, input int d1, input int d2,
                         input int tiles, input bit gaps, input int rmode, input bit stall);
    int err_before;
    int words_before;
    int waited;
    err_before   = errors;
    words_before = words_seen;
    ready_mode   = stall ? 2 : rmode;
    for (int t = 0; t < tiles; t++) begin
      for (int k = 0; k < d2; k++) begin
        exp_q.push_back(ref_word(d1, k, t));
      end
    end
    start_job(d1, d2, tiles);
    if (stall) begin
      fork
        feed_job(d1, d2, tiles, gaps);
        watch_stall(d1 * d2 + d1 * tiles, rmode);
      join
    end else begin
      feed_job(d1, d2, tiles, gaps);
    end
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WORD_TIMEOUT) abort_run("expected output words did not arrive");
    end
    waited = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 20) abort_run("done did not rise after the last word");
    end
    if (out_valid !== 1'b0) begin
      $display("ERROR at %0t: output still valid after done", $time);
      errors++;
    end
    if (words_seen - words_before != d2 * tiles) begin
      $display("MISMATCH at %0t: word count expected %0d got %0d", $time, d2 * tiles,
               words_seen - words_before);
      errors++;
    end
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
    end
  endtask

  initial begin
    reset      = 1'b1;
    start      = 1'b0;
    cfg        = '0;
    in_valid   = 1'b0;
    in_line    = '0;
    data_rng   = 32'ha178;
    ready_rng  = 32'ha178;
    ready_mode = 0;
    errors     = 0;
    words_seen = 0;
    beats_sent = 0;
    tests_run  = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (in_ready !== 1'b0 || out_valid !== 1'b0 || done !== 1'b0) begin
      $display("MISMATCH at %0t: in_ready/out_valid/done expected 000 got %b%b%b",
               $time, in_ready, out_valid, done);
      errors++;
    end

    // fixed samples with one map, one kernel and one tile
    for (int j = 0; j < conv_pkg::LANES; j++) begin
      krn_store[0][j].re = 16'(100 * j - 150);
      krn_store[0][j].im = 16'(7 - 40 * j);
      img_store[0][j].re = 16'(1000 + 3 * j);
      img_store[0][j].im = 16'(-250 * j);
    end
    run_job(1, "single product", 1, 1, 1, 1'b0, 0, 1'b0);

    fill_random(4, 3, 3);
    run_job(2, "three tiles", 4, 3, 3, 1'b0, 0, 1'b0);
    // same data again with gaps on both streams
    run_job(3, "stream gaps", 4, 3, 3, 1'b1, 1, 1'b0);

    fill_random(2, 4, 6);
    run_job(4, "output back-pressure", 2, 4, 6, 1'b0, 0, 1'b1);

    fill_random(3, 5, 2);
    run_job(5, "second config", 3, 5, 2, 1'b1, 1, 1'b0);

    $display("summary: %0d tests, %0d words received, %0d errors", tests_run, words_seen,
             errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/conv_pkg.sv
hw/tile_loader.sv
hw/mac_sequencer.sv
hw/cmac_lane.sv
hw/result_drain.sv
hw/conv_engine_top.sv
sim/tb_conv_engine.sv
